// File: design/kernel_cfg_pkg.sv
// Default configuration of the memory compute unit: sizes, widths and done hold length
package kernel_cfg_pkg;

  // Requestor ports on the request and response side
  localparam int NUM_REQUESTORS = 2;

  // Memory channels, power of two
  localparam int NUM_CHANNELS = 2;

  // Words held by each channel buffer, power of two
  localparam int CHANNEL_WORDS = 16;

  // Width of one data word
  localparam int DATA_WIDTH = 32;

  // Quiet cycles needed before done_out rises
  localparam int PULSE_HOLD = 4;

endpackage : kernel_cfg_pkg

// File: design/mem_packet_pkg.sv
// Memory packet field widths and the channel/offset address union
package mem_packet_pkg;

  import kernel_cfg_pkg::*;

  // Channel select bits, top of the address
  localparam int CHANNEL_BITS = $clog2(NUM_CHANNELS);

  // Word select bits inside one channel
  localparam int OFFSET_BITS = $clog2(CHANNEL_WORDS);

  localparam int ADDR_WIDTH = CHANNEL_BITS + OFFSET_BITS;

  // Requestor tag carried with every packet, never narrower than one bit
  localparam int ID_WIDTH = (NUM_REQUESTORS > 1) ? $clog2(NUM_REQUESTORS) : 1;

  // Split view used by the router
  typedef struct packed {
    logic [CHANNEL_BITS-1:0] channel;
    logic [OFFSET_BITS-1:0]  offset;
  } mem_addr_split_t;

  // One address word, read flat at the ports or split inside the fabric
  typedef union packed {
    logic [ADDR_WIDTH-1:0] flat;
    mem_addr_split_t       split;
  } mem_addr_t;

endpackage : mem_packet_pkg

// File: design/mem_if.sv
// Request and response valid/ready interfaces with source and sink modports
`timescale 1ns/100ps

// ---------------------------------------------------------------------
// Request link
// ---------------------------------------------------------------------
interface mem_req_if import mem_packet_pkg::*; #(
  parameter int DATA_WIDTH = 32
);

  logic                  valid;
  logic                  ready;
  // High for a write, low for a read
  logic                  write;
  mem_addr_t             addr;
  logic [DATA_WIDTH-1:0] data;
  // Requestor that issued the request
  logic [ID_WIDTH-1:0]   id;

  modport source (output valid, write, addr, data, id, input ready);
  modport sink   (input valid, write, addr, data, id, output ready);

endinterface : mem_req_if

// ---------------------------------------------------------------------
// Response link
// ---------------------------------------------------------------------
interface mem_rsp_if import mem_packet_pkg::*; #(
  parameter int DATA_WIDTH = 32
);

  logic                  valid;
  logic                  ready;
  logic                  write;
  mem_addr_t             addr;
  // Read word or echoed write data
  logic [DATA_WIDTH-1:0] data;
  logic [ID_WIDTH-1:0]   id;

  modport source (output valid, write, addr, data, id, input ready);
  modport sink   (input valid, write, addr, data, id, output ready);

endinterface : mem_rsp_if

// File: design/request_arbiter.sv
// Round-robin request arbiter that merges requestor ports into one tagged stream
`timescale 1ns/100ps

module request_arbiter import mem_packet_pkg::*; #(
  parameter int NUM_REQUESTORS = 2,
  parameter int DATA_WIDTH     = 32
) (
  input  logic                                      ap_clk,
  input  logic                                      areset_control,
  input  logic [NUM_REQUESTORS-1:0]                 req_valid,
  input  logic [NUM_REQUESTORS-1:0]                 req_write,
  input  logic [NUM_REQUESTORS-1:0][ADDR_WIDTH-1:0] req_addr,
  input  logic [NUM_REQUESTORS-1:0][DATA_WIDTH-1:0] req_data,
  output logic [NUM_REQUESTORS-1:0]                 req_ready,
  mem_req_if.source                                 out
);

  localparam int LAST = NUM_REQUESTORS - 1;

  logic [ID_WIDTH-1:0] ptr;
  logic                accept_en;
  logic                can_load;
  logic                take;

  // Output register free now or emptied on this edge
  assign can_load = accept_en && (!out.valid || out.ready);
  assign take     = can_load && req_valid[ptr];

  // Only the requestor under the pointer sees ready
  always_comb begin
    req_ready      = '0;
    req_ready[ptr] = can_load;
  end

  // ---------------------------------------------------------------------
  // Rotating priority pointer
  // ---------------------------------------------------------------------
  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      ptr       <= '0;
      accept_en <= 1'b0;
    end else begin
      // Ports open one cycle after reset
      accept_en <= 1'b1;
      // Hold only while the pointed requestor waits on a full register
      if (take || !req_valid[ptr]) begin
        ptr <= (ptr == ID_WIDTH'(LAST)) ? '0 : ptr + 1'b1;
      end
    end
  end

  // ---------------------------------------------------------------------
  // Output register, loaded on the accepting edge
  // ---------------------------------------------------------------------
  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      out.valid <= 1'b0;
    end else if (take) begin
      out.valid <= 1'b1;
    end else if (out.ready) begin
      out.valid <= 1'b0;
    end
  end

  always_ff @(posedge ap_clk) begin
    if (take) begin
      out.write     <= req_write[ptr];
      out.addr.flat <= req_addr[ptr];
      out.data      <= req_data[ptr];
      // Stamp the source so the response finds its way back
      out.id        <= ptr;
    end
  end

endmodule : request_arbiter

// File: design/channel_router.sv
// Channel router that registers the merged request and steers it by address
`timescale 1ns/100ps

module channel_router import mem_packet_pkg::*; #(
  parameter int NUM_CHANNELS = 2
) (
  input  logic      ap_clk,
  input  logic      areset_control,
  mem_req_if.sink   in,
  mem_req_if.source ch [NUM_CHANNELS]
);

  logic                        hold_valid;
  logic                        hold_write;
  mem_addr_t                   hold_addr;
  logic [$bits(in.data)-1:0]   hold_data;
  logic [ID_WIDTH-1:0]         hold_id;
  logic [NUM_CHANNELS-1:0]     ch_ready;

  // Free when empty or when the addressed channel takes the held request
  assign in.ready = !hold_valid || ch_ready[hold_addr.split.channel];

  // Payload fans out to every channel, valid only to the addressed one
  for (genvar c = 0; c < NUM_CHANNELS; c++) begin : g_ch
    assign ch[c].valid = hold_valid && (hold_addr.split.channel == CHANNEL_BITS'(c));
    assign ch[c].write = hold_write;
    assign ch[c].addr  = hold_addr;
    assign ch[c].data  = hold_data;
    assign ch[c].id    = hold_id;
    assign ch_ready[c] = ch[c].ready;
  end

  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      hold_valid <= 1'b0;
    end else if (in.ready) begin
      hold_valid <= in.valid;
    end
  end

  always_ff @(posedge ap_clk) begin
    if (in.valid && in.ready) begin
      hold_write <= in.write;
      hold_addr  <= in.addr;
      hold_data  <= in.data;
      hold_id    <= in.id;
    end
  end

endmodule : channel_router

// File: design/channel_buffer.sv
// Memory channel: local word buffer with a registered read/write response
`timescale 1ns/100ps

module channel_buffer import mem_packet_pkg::*; #(
  parameter int CHANNEL_WORDS = 16,
  parameter int DATA_WIDTH    = 32
) (
  input  logic      ap_clk,
  input  logic      areset_control,
  mem_req_if.sink   req,
  mem_rsp_if.source rsp
);

  logic [DATA_WIDTH-1:0] mem [CHANNEL_WORDS];
  logic [OFFSET_BITS-1:0] offset;
  logic                   take;

  // Channel bits already consumed by the router, only the offset matters here
  assign offset = req.addr.split.offset;

  // Response register empty or handed over this cycle
  assign req.ready = !rsp.valid || rsp.ready;
  assign take      = req.valid && req.ready;

  // ---------------------------------------------------------------------
  // Buffer storage
  // ---------------------------------------------------------------------
  always_ff @(posedge ap_clk) begin
    if (take && req.write) begin
      mem[offset] <= req.data;
    end
  end

  // ---------------------------------------------------------------------
  // Response register
  // ---------------------------------------------------------------------
  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      rsp.valid <= 1'b0;
    end else if (take) begin
      rsp.valid <= 1'b1;
    end else if (rsp.ready) begin
      rsp.valid <= 1'b0;
    end
  end

  always_ff @(posedge ap_clk) begin
    if (take) begin
      rsp.write <= req.write;
      rsp.addr  <= req.addr;
      rsp.id    <= req.id;
      // Reads return the word before this request, writes echo their data
      rsp.data  <= req.write ? req.data : mem[offset];
    end
  end

endmodule : channel_buffer

// File: design/response_arbiter.sv
// Round-robin response arbiter that returns channel responses to their requestors
`timescale 1ns/100ps

module response_arbiter import mem_packet_pkg::*; #(
  parameter int NUM_CHANNELS   = 2,
  parameter int NUM_REQUESTORS = 2,
  parameter int DATA_WIDTH     = 32
) (
  input  logic                                      ap_clk,
  input  logic                                      areset_control,
  mem_rsp_if.sink                                   ch [NUM_CHANNELS],
  input  logic [NUM_REQUESTORS-1:0]                 rsp_ready,
  output logic [NUM_REQUESTORS-1:0]                 rsp_valid,
  output logic [NUM_REQUESTORS-1:0]                 rsp_write,
  output logic [NUM_REQUESTORS-1:0][ADDR_WIDTH-1:0] rsp_addr,
  output logic [NUM_REQUESTORS-1:0][DATA_WIDTH-1:0] rsp_data
);

  localparam int PTR_W = (NUM_CHANNELS > 1) ? $clog2(NUM_CHANNELS) : 1;
  localparam int LAST  = NUM_CHANNELS - 1;

  logic [NUM_CHANNELS-1:0] ch_valid;
  logic [NUM_CHANNELS-1:0] ch_write;
  mem_addr_t               ch_addr [NUM_CHANNELS];
  logic [DATA_WIDTH-1:0]   ch_data [NUM_CHANNELS];
  logic [ID_WIDTH-1:0]     ch_id   [NUM_CHANNELS];
  logic [PTR_W-1:0]        ptr;
  logic                    out_valid;
  logic                    out_write;
  mem_addr_t               out_addr;
  logic [DATA_WIDTH-1:0]   out_data;
  logic [ID_WIDTH-1:0]     out_id;
  logic                    drain;
  logic                    can_load;
  logic                    take;

  // Owner of the held response takes it
  assign drain    = out_valid && rsp_ready[out_id];
  assign can_load = !out_valid || drain;
  assign take     = can_load && ch_valid[ptr];

  // Flatten the channel links, ready only to the channel under the pointer
  for (genvar c = 0; c < NUM_CHANNELS; c++) begin : g_ch
    assign ch_valid[c] = ch[c].valid;
    assign ch_write[c] = ch[c].write;
    assign ch_addr[c]  = ch[c].addr;
    assign ch_data[c]  = ch[c].data;
    assign ch_id[c]    = ch[c].id;
    assign ch[c].ready = can_load && (ptr == PTR_W'(c));
  end

  // ---------------------------------------------------------------------
  // Pointer and output register
  // ---------------------------------------------------------------------
  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      ptr       <= '0;
      out_valid <= 1'b0;
    end else begin
      // Stay on a waiting channel, skip an idle one
      if (take || !ch_valid[ptr]) begin
        ptr <= (ptr == PTR_W'(LAST)) ? '0 : ptr + 1'b1;
      end
      if (take) begin
        out_valid <= 1'b1;
      end else if (drain) begin
        out_valid <= 1'b0;
      end
    end
  end

  always_ff @(posedge ap_clk) begin
    if (take) begin
      out_write <= ch_write[ptr];
      out_addr  <= ch_addr[ptr];
      out_data  <= ch_data[ptr];
      out_id    <= ch_id[ptr];
    end
  end

  // Payload is shared, valid goes to the tagged requestor only
  always_comb begin
    for (int r = 0; r < NUM_REQUESTORS; r++) begin
      rsp_valid[r] = out_valid && (out_id == ID_WIDTH'(r));
      rsp_write[r] = out_write;
      rsp_addr[r]  = out_addr.flat;
      rsp_data[r]  = out_data;
    end
  end

endmodule : response_arbiter

// File: design/kernel_cu.sv
// Compute unit top: request/response fabric, channel buffers, in-flight count, done detector
`timescale 1ns/100ps

module kernel_cu import mem_packet_pkg::*; #(
  parameter int NUM_REQUESTORS = kernel_cfg_pkg::NUM_REQUESTORS,
  parameter int NUM_CHANNELS   = kernel_cfg_pkg::NUM_CHANNELS,
  parameter int CHANNEL_WORDS  = kernel_cfg_pkg::CHANNEL_WORDS,
  parameter int DATA_WIDTH     = kernel_cfg_pkg::DATA_WIDTH,
  parameter int PULSE_HOLD     = kernel_cfg_pkg::PULSE_HOLD
) (
  input  logic                                      ap_clk,
  input  logic                                      areset_control,
  input  logic [NUM_REQUESTORS-1:0]                 req_valid,
  output logic [NUM_REQUESTORS-1:0]                 req_ready,
  input  logic [NUM_REQUESTORS-1:0]                 req_write,
  input  logic [NUM_REQUESTORS-1:0][ADDR_WIDTH-1:0] req_addr,
  input  logic [NUM_REQUESTORS-1:0][DATA_WIDTH-1:0] req_data,
  output logic [NUM_REQUESTORS-1:0]                 rsp_valid,
  input  logic [NUM_REQUESTORS-1:0]                 rsp_ready,
  output logic [NUM_REQUESTORS-1:0]                 rsp_write,
  output logic [NUM_REQUESTORS-1:0][ADDR_WIDTH-1:0] rsp_addr,
  output logic [NUM_REQUESTORS-1:0][DATA_WIDTH-1:0] rsp_data,
  input  logic [NUM_REQUESTORS-1:0]                 work_done,
  output logic                                      done_out
);

  // Enough for every register stage of the fabric to hold one request
  localparam int CNT_W = $clog2(NUM_CHANNELS + 4) + 1;

  logic [CNT_W-1:0]      inflight;
  logic                  req_fire;
  logic                  rsp_fire;
  logic                  quiet;
  logic [PULSE_HOLD-1:0] done_hist;

  mem_req_if #(.DATA_WIDTH(DATA_WIDTH)) merged_req ();
  mem_req_if #(.DATA_WIDTH(DATA_WIDTH)) ch_req [NUM_CHANNELS] ();
  mem_rsp_if #(.DATA_WIDTH(DATA_WIDTH)) ch_rsp [NUM_CHANNELS] ();

  // ---------------------------------------------------------------------
  // Request side
  // ---------------------------------------------------------------------
  request_arbiter #(
    .NUM_REQUESTORS(NUM_REQUESTORS),
    .DATA_WIDTH    (DATA_WIDTH)
  ) u_request_arbiter (
    .ap_clk        (ap_clk),
    .areset_control(areset_control),
    .req_valid     (req_valid),
    .req_write     (req_write),
    .req_addr      (req_addr),
    .req_data      (req_data),
    .req_ready     (req_ready),
    .out           (merged_req)
  );

  channel_router #(
    .NUM_CHANNELS(NUM_CHANNELS)
  ) u_channel_router (
    .ap_clk        (ap_clk),
    .areset_control(areset_control),
    .in            (merged_req),
    .ch            (ch_req)
  );

  // One buffer per memory channel
  for (genvar c = 0; c < NUM_CHANNELS; c++) begin : g_channel
    channel_buffer #(
      .CHANNEL_WORDS(CHANNEL_WORDS),
      .DATA_WIDTH   (DATA_WIDTH)
    ) u_channel_buffer (
      .ap_clk        (ap_clk),
      .areset_control(areset_control),
      .req           (ch_req[c]),
      .rsp           (ch_rsp[c])
    );
  end

  // ---------------------------------------------------------------------
  // Response side
  // ---------------------------------------------------------------------
  response_arbiter #(
    .NUM_CHANNELS  (NUM_CHANNELS),
    .NUM_REQUESTORS(NUM_REQUESTORS),
    .DATA_WIDTH    (DATA_WIDTH)
  ) u_response_arbiter (
    .ap_clk        (ap_clk),
    .areset_control(areset_control),
    .ch            (ch_rsp),
    .rsp_ready     (rsp_ready),
    .rsp_valid     (rsp_valid),
    .rsp_write     (rsp_write),
    .rsp_addr      (rsp_addr),
    .rsp_data      (rsp_data)
  );

  // ---------------------------------------------------------------------
  // In-flight count and done detection
  // ---------------------------------------------------------------------
  // At most one transfer per side per cycle
  assign req_fire = |(req_valid & req_ready);
  assign rsp_fire = |(rsp_valid & rsp_ready);

  // All requestors finished and the fabric empty
  assign quiet = (&work_done) && (inflight == '0);

  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      inflight  <= '0;
      done_hist <= '0;
    end else begin
      inflight  <= inflight + CNT_W'(req_fire) - CNT_W'(rsp_fire);
      // History of the last PULSE_HOLD quiet samples
      done_hist <= (done_hist << 1) | PULSE_HOLD'(quiet);
    end
  end

  // High once every sample in the window was quiet
  assign done_out = &done_hist;

endmodule : kernel_cu

// File: bench/kernel_cu_sva.sv
// Handshake, response exclusivity and done assertions for kernel_cu, with their bind
`timescale 1ns/100ps

module kernel_cu_sva import mem_packet_pkg::*; #(
  parameter int NUM_REQUESTORS = 2,
  parameter int DATA_WIDTH     = 32
) (
  input logic                                      ap_clk,
  input logic                                      areset_control,
  input logic [NUM_REQUESTORS-1:0]                 req_valid,
  input logic [NUM_REQUESTORS-1:0]                 req_ready,
  input logic [NUM_REQUESTORS-1:0]                 req_write,
  input logic [NUM_REQUESTORS-1:0][ADDR_WIDTH-1:0] req_addr,
  input logic [NUM_REQUESTORS-1:0][DATA_WIDTH-1:0] req_data,
  input logic [NUM_REQUESTORS-1:0]                 rsp_valid,
  input logic [NUM_REQUESTORS-1:0]                 rsp_ready,
  input logic [NUM_REQUESTORS-1:0]                 rsp_write,
  input logic [NUM_REQUESTORS-1:0][ADDR_WIDTH-1:0] rsp_addr,
  input logic [NUM_REQUESTORS-1:0][DATA_WIDTH-1:0] rsp_data,
  input logic [NUM_REQUESTORS-1:0]                 work_done,
  input logic                                      done_out
);

  // ---------------------------------------------------------------------
  // Valid held with stable fields until the transfer
  // ---------------------------------------------------------------------
  for (genvar r = 0; r < NUM_REQUESTORS; r++) begin : g_port
    a_req_hold: assert property (@(posedge ap_clk) disable iff (areset_control)
      req_valid[r] && !req_ready[r] |=> req_valid[r] && $stable(req_write[r])
        && $stable(req_addr[r]) && $stable(req_data[r]))
      else $error("request port %0d changed before acceptance", r);

    a_rsp_hold: assert property (@(posedge ap_clk) disable iff (areset_control)
      rsp_valid[r] && !rsp_ready[r] |=> rsp_valid[r] && $stable(rsp_write[r])
        && $stable(rsp_addr[r]) && $stable(rsp_data[r]))
      else $error("response port %0d changed before acceptance", r);
  end

  // Single response register, so one owner at a time
  a_rsp_onehot: assert property (@(posedge ap_clk) disable iff (areset_control)
    $onehot0(rsp_valid))
    else $error("more than one rsp_valid bit high");

  // done_out is registered, it follows work_done one edge late
  a_done_work: assert property (@(posedge ap_clk) disable iff (areset_control)
    done_out |-> &($past(work_done)))
    else $error("done_out high while a work_done bit was low");

endmodule : kernel_cu_sva

bind kernel_cu kernel_cu_sva #(
  .NUM_REQUESTORS(NUM_REQUESTORS),
  .DATA_WIDTH    (DATA_WIDTH)
) u_sva (
  .ap_clk        (ap_clk),
  .areset_control(areset_control),
  .req_valid     (req_valid),
  .req_ready     (req_ready),
  .req_write     (req_write),
  .req_addr      (req_addr),
  .req_data      (req_data),
  .rsp_valid     (rsp_valid),
  .rsp_ready     (rsp_ready),
  .rsp_write     (rsp_write),
  .rsp_addr      (rsp_addr),
  .rsp_data      (rsp_data),
  .work_done     (work_done),
  .done_out      (done_out)
);

// File: bench/tb_kernel_cu.sv
// Testbench for kernel_cu: random traffic, reference memory, response queues, done checks
`timescale 1ns/100ps

module tb_kernel_cu
  import kernel_cfg_pkg::*;
  import mem_packet_pkg::*;
();

  localparam int SEED         = 75329;
  localparam int CLK_PERIOD   = 100;
  localparam int RESET_CYCLES = 4;
  localparam int DRIVE_DELAY  = 1;
  // Each requestor owns its own slice of every channel's offsets
  localparam int SLOT_WORDS   = CHANNEL_WORDS / NUM_REQUESTORS;
  localparam int INIT_WRITES  = NUM_CHANNELS * SLOT_WORDS;
  localparam int RANDOM_OPS   = 60;
  localparam int LATE_OPS     = 4;
  localparam int NUM_TRANS    = NUM_REQUESTORS * (INIT_WRITES + RANDOM_OPS + LATE_OPS);
  localparam int TIMEOUT_CYCLES = 40 * NUM_TRANS + 200;
  localparam int NUM_QUEUES   = NUM_REQUESTORS * NUM_CHANNELS;

  typedef struct packed {
    logic                  write;
    mem_addr_t             addr;
    logic [DATA_WIDTH-1:0] data;
  } txn_t;

  logic                                      ap_clk;
  logic                                      areset_control;
  logic [NUM_REQUESTORS-1:0]                 req_valid;
  logic [NUM_REQUESTORS-1:0]                 req_ready;
  logic [NUM_REQUESTORS-1:0]                 req_write;
  logic [NUM_REQUESTORS-1:0][ADDR_WIDTH-1:0] req_addr;
  logic [NUM_REQUESTORS-1:0][DATA_WIDTH-1:0] req_data;
  logic [NUM_REQUESTORS-1:0]                 rsp_valid;
  logic [NUM_REQUESTORS-1:0]                 rsp_ready;
  logic [NUM_REQUESTORS-1:0]                 rsp_write;
  logic [NUM_REQUESTORS-1:0][ADDR_WIDTH-1:0] rsp_addr;
  logic [NUM_REQUESTORS-1:0][DATA_WIDTH-1:0] rsp_data;
  logic [NUM_REQUESTORS-1:0]                 work_done;
  logic                                      done_out;

  // Model state
  logic [DATA_WIDTH-1:0]     ref_mem [2**ADDR_WIDTH];
  txn_t                      stim_q [NUM_REQUESTORS][$];
  txn_t                      expect_q [NUM_QUEUES][$];
  logic [NUM_REQUESTORS-1:0] accepted;
  logic [NUM_REQUESTORS-1:0] work_done_next;
  int                        issued;
  int                        received;
  int                        quiet_run;
  int                        cycle_count;

  kernel_cu u_dut (
    .ap_clk        (ap_clk),
    .areset_control(areset_control),
    .req_valid     (req_valid),
    .req_ready     (req_ready),
    .req_write     (req_write),
    .req_addr      (req_addr),
    .req_data      (req_data),
    .rsp_valid     (rsp_valid),
    .rsp_ready     (rsp_ready),
    .rsp_write     (rsp_write),
    .rsp_addr      (rsp_addr),
    .rsp_data      (rsp_data),
    .work_done     (work_done),
    .done_out      (done_out)
  );

  initial begin
    ap_clk = 1'b0;
    forever #(CLK_PERIOD / 2) ap_clk = ~ap_clk;
  end

  // ---------------------------------------------------------------------
  // Error reporting and compare tasks
  // ---------------------------------------------------------------------
  task automatic stop_with_error(input string msg);
    $display("%s", msg);
    $display("Test FAILED");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  task automatic check_data(input string name, input logic [DATA_WIDTH-1:0] got,
                            input logic [DATA_WIDTH-1:0] exp);
    if (got !== exp) begin
      stop_with_error($sformatf("FAIL %s: got 0x%h, expected 0x%h", name, got, exp));
    end
  endtask

  task automatic check_addr(input string name, input mem_addr_t got, input mem_addr_t exp);
    if (got.flat !== exp.flat) begin
      stop_with_error($sformatf("FAIL %s: got 0x%h, expected 0x%h", name, got.flat,
                                exp.flat));
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      stop_with_error($sformatf("FAIL %s: got 0x%h, expected 0x%h", name, got, exp));
    end
  endtask

  // Run limit scaled to the transaction count
  initial begin
    cycle_count = 0;
    forever begin
      @(posedge ap_clk);
      cycle_count++;
      if (cycle_count > TIMEOUT_CYCLES) begin
        stop_with_error("Timeout: responses did not drain within the cycle limit");
      end
    end
  end

  // ---------------------------------------------------------------------
  // Stimulus
  // ---------------------------------------------------------------------
  function automatic txn_t random_txn(input int r);
    txn_t t;
    t.write              = 1'($urandom_range(1));
    t.addr.split.channel = CHANNEL_BITS'($urandom_range(NUM_CHANNELS - 1));
    t.addr.split.offset  = OFFSET_BITS'(r * SLOT_WORDS + $urandom_range(SLOT_WORDS - 1));
    t.data               = DATA_WIDTH'($urandom);
    return t;
  endfunction

  // Write pass over every owned word, then random reads and writes
  task automatic build_stimulus();
    txn_t t;
    for (int r = 0; r < NUM_REQUESTORS; r++) begin
      for (int c = 0; c < NUM_CHANNELS; c++) begin
        for (int k = 0; k < SLOT_WORDS; k++) begin
          t.write              = 1'b1;
          t.addr.split.channel = CHANNEL_BITS'(c);
          t.addr.split.offset  = OFFSET_BITS'(r * SLOT_WORDS + k);
          t.data               = DATA_WIDTH'($urandom);
          stim_q[r].push_back(t);
        end
      end
      repeat (RANDOM_OPS) stim_q[r].push_back(random_txn(r));
    end
  endtask

  function automatic bit traffic_drained();
    for (int r = 0; r < NUM_REQUESTORS; r++) begin
      if (stim_q[r].size() != 0 || req_valid[r]) return 1'b0;
    end
    return issued == received;
  endfunction

  // New inputs a short delay after the edge, pending requests held
  task automatic drive_inputs();
    txn_t t;
    @(posedge ap_clk);
    #DRIVE_DELAY;
    work_done = work_done_next;
    for (int r = 0; r < NUM_REQUESTORS; r++) begin
      if (!req_valid[r] || accepted[r]) begin
        if (stim_q[r].size() > 0 && $urandom_range(3) != 0) begin
          t            = stim_q[r].pop_front();
          req_valid[r] = 1'b1;
          req_write[r] = t.write;
          req_addr[r]  = t.addr.flat;
          req_data[r]  = t.data;
        end else begin
          req_valid[r] = 1'b0;
        end
      end
      rsp_ready[r] = ($urandom_range(3) != 0);
    end
  endtask

  // ---------------------------------------------------------------------
  // Sampling at the falling edge, where everything is settled
  // ---------------------------------------------------------------------
  task automatic sample_outputs();
    txn_t t;
    txn_t e;
    int   q;
    logic quiet;
    @(negedge ap_clk);
    // Done model, quiet judged before this cycle's transfers count
    check_flag("done_out", done_out, quiet_run >= PULSE_HOLD);
    quiet     = (&work_done) && (issued == received);
    quiet_run = quiet ? quiet_run + 1 : 0;
    for (int r = 0; r < NUM_REQUESTORS; r++) begin
      accepted[r] = req_valid[r] && req_ready[r];
      if (accepted[r]) begin
        t.write     = req_write[r];
        t.addr.flat = req_addr[r];
        t.data      = req_data[r];
        // Reads see the word as it stands at issue
        if (t.write) begin
          ref_mem[t.addr.flat] = t.data;
        end else begin
          t.data = ref_mem[t.addr.flat];
        end
        q = r * NUM_CHANNELS + int'(t.addr.split.channel);
        expect_q[q].push_back(t);
        issued++;
      end
      if (rsp_valid[r] && rsp_ready[r]) begin
        t.addr.flat = rsp_addr[r];
        q = r * NUM_CHANNELS + int'(t.addr.split.channel);
        if (expect_q[q].size() == 0) begin
          stop_with_error($sformatf("Requestor %0d got a response it never asked for", r));
        end
        e = expect_q[q].pop_front();
        check_flag($sformatf("rsp_write[%0d]", r), rsp_write[r], e.write);
        check_addr($sformatf("rsp_addr[%0d]", r), t.addr, e.addr);
        check_data($sformatf("rsp_data[%0d]", r), rsp_data[r], e.data);
        received++;
      end
    end
  endtask

  task automatic run_cycle();
    drive_inputs();
    sample_outputs();
  endtask

  // ---------------------------------------------------------------------
  // Test sequence
  // ---------------------------------------------------------------------
  initial begin
    void'($urandom(SEED));
    areset_control = 1'b1;
    req_valid      = '0;
    req_write      = '0;
    req_addr       = '0;
    req_data       = '0;
    rsp_ready      = '0;
    work_done      = '0;
    work_done_next = '0;
    accepted       = '0;
    issued         = 0;
    received       = 0;
    quiet_run      = 0;
    build_stimulus();
    repeat (RESET_CYCLES) @(posedge ap_clk);
    #DRIVE_DELAY;
    areset_control = 1'b0;

    // Fabric idle straight out of reset
    @(negedge ap_clk);
    check_flag("rsp_valid", |rsp_valid, 1'b0);
    check_flag("req_ready", |req_ready, 1'b0);
    check_flag("done_out", done_out, 1'b0);

    // Write pass and random traffic with work still pending
    while (!traffic_drained()) run_cycle();

    // Every requestor done, done_out rises after the hold window
    work_done_next = '1;
    repeat (PULSE_HOLD + 2) run_cycle();
    check_flag("done_out", done_out, 1'b1);

    // One requestor back at work
    work_done_next[0] = 1'b0;
    repeat (3) run_cycle();
    check_flag("done_out", done_out, 1'b0);

    // Late traffic while all report done, outstanding responses hold done_out low
    work_done_next = '1;
    for (int r = 0; r < NUM_REQUESTORS; r++) begin
      repeat (LATE_OPS) stim_q[r].push_back(random_txn(r));
    end
    while (!traffic_drained()) run_cycle();
    repeat (PULSE_HOLD + 2) run_cycle();
    check_flag("done_out", done_out, 1'b1);

    $display("Test OK");
    $finish;
  end

endmodule : tb_kernel_cu

// File: filelist.f
design/kernel_cfg_pkg.sv
design/mem_packet_pkg.sv
design/mem_if.sv
design/request_arbiter.sv
design/channel_router.sv
design/channel_buffer.sv
design/response_arbiter.sv
design/kernel_cu.sv
bench/kernel_cu_sva.sv
bench/tb_kernel_cu.sv

// File: Makefile
SIM      = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = tb_kernel_cu
FILELIST = filelist.f
OBJ_DIR  = obj_dir
PASS_MSG = Test OK

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build and run the simulation, fail unless the pass message is printed"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
